// ==== dmaController.f ====
+incdir+test
hdl/dmaPkg.sv
hdl/dmaRegisterFile.sv
hdl/dmaChannelCounters.sv
hdl/dmaPriorityArbiter.sv
hdl/dmaTimingControl.sv
hdl/dmaController.sv
test/dmaControllerTb.sv

// ==== Bender.yml ====
package:
  name: dma_controller

sources:
  - files:
      - hdl/dmaPkg.sv
      - hdl/dmaRegisterFile.sv
      - hdl/dmaChannelCounters.sv
      - hdl/dmaPriorityArbiter.sv
      - hdl/dmaTimingControl.sv
      - hdl/dmaController.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/dmaControllerTb.sv

// ==== test/dmaControllerModel.svh ====
`ifndef DMA_CONTROLLER_MODEL_SVH
`define DMA_CONTROLLER_MODEL_SVH

// reference copy of the current and base registers per channel
logic [dmaPkg::addrWidth-1:0] refAddr [dmaPkg::numChannels];
logic [dmaPkg::addrWidth-1:0] refCount [dmaPkg::numChannels];
logic [dmaPkg::addrWidth-1:0] refBaseAddr [dmaPkg::numChannels];
logic [dmaPkg::addrWidth-1:0] refBaseCount [dmaPkg::numChannels];
// mode fields per channel
logic [dmaPkg::xferWidth-1:0] refType [dmaPkg::numChannels];
logic refAutoInit [dmaPkg::numChannels];
logic refDecrement [dmaPkg::numChannels];
// status, byte pointer and priority state
logic [dmaPkg::numChannels-1:0] refTcFlags;
logic refByteFf;
logic refRotating;
logic [dmaPkg::channelIdxWidth-1:0] refTopChannel;

// state after the reset pin
function automatic void resetState();
	refTcFlags = '0;
	refByteFf = 1'b0;
	refRotating = 1'b0;
	refTopChannel = '0;
	for (int ch = 0; ch < dmaPkg::numChannels; ch++)
	begin
		refType[ch] = dmaPkg::xferVerify;
		refAutoInit[ch] = 1'b0;
		refDecrement[ch] = 1'b0;
	end
endfunction

// CPU write as seen by the registers
function automatic void applyWrite(input logic [3:0] idx, input logic [7:0] data);
	int ch;
	int lane;
	ch = int'(idx) / 2;
	lane = refByteFf ? 8 : 0;
	if (idx < 4'd8)
	begin
		// even index is the address, odd index the count, base follows current
		if (idx[0])
		begin
			refCount[ch][lane +: 8] = data;
			refBaseCount[ch][lane +: 8] = data;
		end
		else
		begin
			refAddr[ch][lane +: 8] = data;
			refBaseAddr[ch][lane +: 8] = data;
		end
		refByteFf = !refByteFf;
	end
	else if (idx == dmaPkg::regCmdStatus)
		refRotating = data[4];
	else if (idx == dmaPkg::regMode)
	begin
		// mode byte carries its own channel in bits 1 and 0
		refType[data[1:0]] = data[3:2];
		refAutoInit[data[1:0]] = data[4];
		refDecrement[data[1:0]] = data[5];
	end
	else if (idx == dmaPkg::regClearFf)
		refByteFf = 1'b0;
endfunction

// expected read byte, with the side effects of the read
function automatic logic [7:0] predictRead(input logic [3:0] idx);
	logic [15:0] word;
	logic [7:0] value;
	value = 8'h00;
	if (idx < 4'd8)
	begin
		word = idx[0] ? refCount[int'(idx) / 2] : refAddr[int'(idx) / 2];
		value = refByteFf ? word[15:8] : word[7:0];
		refByteFf = !refByteFf;
	end
	else if (idx == dmaPkg::regCmdStatus)
	begin
		value = {4'b0000, refTcFlags};
		refTcFlags = '0;
	end
	return value;
endfunction

// channel that should win for a given request vector
function automatic logic [1:0] pickChannel(input logic [3:0] req);
	logic [1:0] first;
	logic [1:0] pick;
	first = refRotating ? refTopChannel : 2'd0;
	pick = first;
	// walk from the lowest priority up, so the highest requester is kept last
	for (int k = 3; k >= 0; k--)
		if (req[(first + k) % 4])
			pick = 2'((first + k) % 4);
	return pick;
endfunction

// one finished transfer on a channel
function automatic void stepChannel(input logic [1:0] ch);
	if (refCount[ch] == 16'h0000)
		refTcFlags[ch] = 1'b1;
	if (refCount[ch] == 16'h0000 && refAutoInit[ch])
	begin
		refAddr[ch] = refBaseAddr[ch];
		refCount[ch] = refBaseCount[ch];
	end
	else
	begin
		refAddr[ch] = refDecrement[ch] ? refAddr[ch] - 16'd1 : refAddr[ch] + 16'd1;
		refCount[ch] = refCount[ch] - 16'd1;
	end
	// serviced channel drops to lowest priority
	refTopChannel = ch + 2'd1;
endfunction

`endif

// ==== test/dmaControllerTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dmaControllerTb;

	logic busIf;
	logic arstN;
	logic csN;
	logic iorN;
	logic iowN;
	logic [dmaPkg::regIdxWidth-1:0] regIdx;
	logic [dmaPkg::dataWidth-1:0] dbIn;
	logic [dmaPkg::dataWidth-1:0] dbOut;
	logic dbOe;
	logic [dmaPkg::numChannels-1:0] dreq;
	logic hlda;
	logic hrq;
	logic aen;
	logic adstb;
	logic [dmaPkg::numChannels-1:0] dack;
	logic [dmaPkg::addrWidth-1:0] addrOut;
	logic dmaIorN;
	logic dmaIowN;
	logic memrN;
	logic memwN;

	// requests the devices currently hold high
	logic [dmaPkg::numChannels-1:0] dreqVal;
	integer seed;

	`include "dmaControllerModel.svh"

	dmaController i_dmaController (.*);

	// 8 ns clock
	initial
	begin
		busIf = 1'b0;
		forever
			#4 busIf = !busIf;
	end

	task automatic abortRun();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("FAIL time=%0t signal=%s expected=0x%0h actual=0x%0h",
				$time, name, expected, actual);
			abortRun();
		end
	endtask

	task automatic timedOut(input string what);
		$display("timeout while waiting for %s", what);
		abortRun();
	endtask

	// single-cycle CPU write strobe
	task automatic writeReg(input logic [3:0] idx, input logic [7:0] data);
		@(negedge busIf);
		csN = 1'b0;
		iowN = 1'b0;
		regIdx = idx;
		dbIn = data;
		applyWrite(idx, data);
		@(negedge busIf);
		csN = 1'b1;
		iowN = 1'b1;
	endtask

	// single-cycle CPU read, data and enable show up one cycle later
	task automatic readReg(input logic [3:0] idx, input string name);
		logic [7:0] expected;
		@(negedge busIf);
		csN = 1'b0;
		iorN = 1'b0;
		regIdx = idx;
		expected = predictRead(idx);
		@(negedge busIf);
		csN = 1'b1;
		iorN = 1'b1;
		checkValue("dbOe after read", 1, dbOe);
		checkValue(name, expected, dbOut);
		@(negedge busIf);
		checkValue("dbOe one cycle later", 0, dbOe);
	endtask

	task automatic programMode(input logic [1:0] ch, input logic [1:0] xfer,
		input logic autoInit, input logic decrement);
		// single transfer mode in the top two bits
		writeReg(dmaPkg::regMode, {2'b01, decrement, autoInit, xfer, ch});
	endtask

	// one full DREQ, HRQ, HLDA, DACK exchange, checked state by state
	task automatic runTransfer(input logic dropReq);
		logic [1:0] ch;
		logic isWrite;
		logic isRead;
		logic [15:0] expAddr;
		logic [3:0] expDack;
		int cycles;
		int latency;
		ch = pickChannel(dreqVal);
		isWrite = refType[ch] == dmaPkg::xferWrite;
		isRead = refType[ch] == dmaPkg::xferRead;
		expAddr = refAddr[ch];
		expDack = 4'b0001 << ch;
		cycles = 0;
		while (!hrq)
		begin
			@(negedge busIf);
			cycles++;
			if (cycles > 16)
				timedOut("hrq after a raised dreq");
		end
		// host takes a few cycles to grant the bus
		latency = $random(seed) & 3;
		repeat (latency) @(negedge busIf);
		hlda = 1'b1;
		cycles = 0;
		while (!aen)
		begin
			@(negedge busIf);
			cycles++;
			if (cycles > 8)
				timedOut("aen after hlda");
		end
		// S1, address strobe only
		checkValue("adstb in S1", 1, adstb);
		checkValue("dack in S1", 0, dack);
		checkValue("addrOut in S1", expAddr, addrOut);
		checkValue("strobes in S1", 4'b1111, {dmaIorN, dmaIowN, memrN, memwN});
		@(negedge busIf);
		checkValue("aen in S2", 1, aen);
		checkValue("adstb in S2", 0, adstb);
		checkValue("dack in S2", expDack, dack);
		checkValue("addrOut in S2", expAddr, addrOut);
		checkValue("strobes in S2", {!isWrite, 1'b1, !isRead, 1'b1},
			{dmaIorN, dmaIowN, memrN, memwN});
		// device lets go of its request once acknowledged
		if (dropReq)
		begin
			dreqVal[ch] = 1'b0;
			dreq = dreqVal;
		end
		@(negedge busIf);
		checkValue("aen in S4", 0, aen);
		checkValue("adstb in S4", 0, adstb);
		checkValue("dack in S4", expDack, dack);
		checkValue("addrOut in S4", expAddr, addrOut);
		checkValue("strobes in S4", {!isWrite, !isRead, !isRead, !isWrite},
			{dmaIorN, dmaIowN, memrN, memwN});
		@(negedge busIf);
		checkValue("hrq after S4", 0, hrq);
		checkValue("dack after S4", 0, dack);
		checkValue("strobes after S4", 4'b1111, {dmaIorN, dmaIowN, memrN, memwN});
		hlda = 1'b0;
		stepChannel(ch);
	endtask

	initial
	begin
		logic [31:0] value;
		logic [1:0] tcCh;
		logic [2:0] tcCount;
		seed = 80;
		arstN = 1'b0;
		csN = 1'b1;
		iorN = 1'b1;
		iowN = 1'b1;
		regIdx = '0;
		dbIn = '0;
		dreq = '0;
		dreqVal = '0;
		hlda = 1'b0;
		resetState();
		repeat (4) @(negedge busIf);
		arstN = 1'b1;
		@(negedge busIf);

		// idle outputs after reset
		checkValue("hrq", 0, hrq);
		checkValue("aen", 0, aen);
		checkValue("adstb", 0, adstb);
		checkValue("dack", 0, dack);
		checkValue("dbOe", 0, dbOe);
		checkValue("strobes", 4'b1111, {dmaIorN, dmaIowN, memrN, memwN});

		// random address and count per channel, low byte first
		writeReg(dmaPkg::regClearFf, 8'h00);
		for (int idx = 0; idx < 8; idx++)
		begin
			value = $random(seed);
			writeReg(4'(idx), value[7:0]);
			writeReg(4'(idx), value[15:8]);
		end
		writeReg(dmaPkg::regClearFf, 8'h00);
		for (int idx = 0; idx < 8; idx++)
		begin
			readReg(4'(idx), "dbOut low byte");
			readReg(4'(idx), "dbOut high byte");
		end

		// fixed priority, lowest requesting channel goes first
		writeReg(dmaPkg::regCmdStatus, 8'h00);
		for (int ch = 0; ch < 4; ch++)
		begin
			value = $random(seed);
			programMode(2'(ch), 2'(value[7:0] % 3), value[8], value[9]);
		end
		for (int round = 0; round < 4; round++)
		begin
			value = $random(seed);
			dreqVal = (value[3:0] == 4'h0) ? 4'h8 : value[3:0];
			dreq = dreqVal;
			while (dreqVal != 4'h0)
				runTransfer(1'b1);
		end

		// rotating priority with every channel requesting
		writeReg(dmaPkg::regCmdStatus, 8'h10);
		dreqVal = 4'hf;
		dreq = dreqVal;
		repeat (8) runTransfer(1'b0);
		dreqVal = 4'h0;
		dreq = dreqVal;

		// terminal count with autoinit on one channel
		writeReg(dmaPkg::regCmdStatus, 8'h00);
		readReg(dmaPkg::regCmdStatus, "status before tc");
		value = $random(seed);
		tcCh = value[1:0];
		tcCount = value[4:2];
		programMode(tcCh, 2'(value[15:8] % 3), 1'b1, value[5]);
		writeReg(dmaPkg::regClearFf, 8'h00);
		value = $random(seed);
		writeReg({1'b0, tcCh, 1'b0}, value[7:0]);
		writeReg({1'b0, tcCh, 1'b0}, value[15:8]);
		writeReg({1'b0, tcCh, 1'b1}, {5'b00000, tcCount});
		writeReg({1'b0, tcCh, 1'b1}, 8'h00);
		// count+1 transfers wrap the count and trigger the reload
		for (int n = 0; n <= int'(tcCount); n++)
		begin
			dreqVal = 4'b0001 << tcCh;
			dreq = dreqVal;
			runTransfer(1'b1);
		end
		readReg(dmaPkg::regCmdStatus, "status with tc");
		readReg(dmaPkg::regCmdStatus, "status after clear");
		writeReg(dmaPkg::regClearFf, 8'h00);
		readReg({1'b0, tcCh, 1'b0}, "reloaded address low");
		readReg({1'b0, tcCh, 1'b0}, "reloaded address high");
		readReg({1'b0, tcCh, 1'b1}, "reloaded count low");
		readReg({1'b0, tcCh, 1'b1}, "reloaded count high");

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/dmaController.sv ====
`timescale 1ns/1ns
`default_nettype none

module dmaController (
	input  logic                            busIf,
	input  logic                            arstN,
	input  logic                            csN,
	input  logic                            iorN,
	input  logic                            iowN,
	input  logic [dmaPkg::regIdxWidth-1:0]  regIdx,
	input  logic [dmaPkg::dataWidth-1:0]    dbIn,
	output logic [dmaPkg::dataWidth-1:0]    dbOut,
	output logic                            dbOe,
	input  logic [dmaPkg::numChannels-1:0]  dreq,
	input  logic                            hlda,
	output logic                            hrq,
	output logic                            aen,
	output logic                            adstb,
	output logic [dmaPkg::numChannels-1:0]  dack,
	output logic [dmaPkg::addrWidth-1:0]    addrOut,
	output logic                            dmaIorN,
	output logic                            dmaIowN,
	output logic                            memrN,
	output logic                            memwN
);

	// register file to counters
	logic loadStrobe;
	logic [dmaPkg::channelIdxWidth-1:0] loadChannel;
	logic loadIsCount;
	logic loadHigh;
	logic [dmaPkg::dataWidth-1:0] loadByte;
	logic [dmaPkg::channelIdxWidth-1:0] readChannel;
	logic readIsCount;
	logic readHigh;
	logic [dmaPkg::numChannels-1:0][dmaPkg::addrWidth-1:0] baseAddr;
	logic [dmaPkg::numChannels-1:0][dmaPkg::addrWidth-1:0] baseCount;
	logic [dmaPkg::numChannels-1:0] autoInit;
	logic [dmaPkg::numChannels-1:0] addrDecrement;
	// counters back to the register file and the FSM
	logic [dmaPkg::dataWidth-1:0] curByte;
	logic [dmaPkg::numChannels-1:0][dmaPkg::addrWidth-1:0] curAddr;
	logic tcPulse;
	logic [dmaPkg::channelIdxWidth-1:0] tcChannel;
	// command and mode fields to arbiter and FSM
	logic controllerDisable;
	logic rotatingPriority;
	logic [dmaPkg::numChannels-1:0][dmaPkg::xferWidth-1:0] transferType;
	// grant and end of transfer
	logic requestValid;
	logic [dmaPkg::channelIdxWidth-1:0] grantChannel;
	logic transferDone;
	logic [dmaPkg::channelIdxWidth-1:0] doneChannel;

	dmaRegisterFile i_registerFile (.*);

	dmaChannelCounters i_channelCounters (.*);

	dmaPriorityArbiter i_priorityArbiter (.*);

	dmaTimingControl i_timingControl (.*);

endmodule

`default_nettype wire

// ==== hdl/dmaTimingControl.sv ====
`timescale 1ns/1ns
`default_nettype none

module dmaTimingControl (
	input  logic                                              busIf,
	input  logic                                              arstN,
	input  logic                                              requestValid,
	input  logic [dmaPkg::channelIdxWidth-1:0]                grantChannel,
	input  logic                                              hlda,
	input  logic [dmaPkg::numChannels-1:0][dmaPkg::xferWidth-1:0] transferType,
	input  logic [dmaPkg::numChannels-1:0][dmaPkg::addrWidth-1:0] curAddr,
	output logic                                              hrq,
	output logic                                              aen,
	output logic                                              adstb,
	output logic [dmaPkg::numChannels-1:0]                    dack,
	output logic [dmaPkg::addrWidth-1:0]                      addrOut,
	output logic                                              dmaIorN,
	output logic                                              dmaIowN,
	output logic                                              memrN,
	output logic                                              memwN,
	output logic                                              transferDone,
	output logic [dmaPkg::channelIdxWidth-1:0]                doneChannel
);

	logic [dmaPkg::stateWidth-1:0] state;
	logic [dmaPkg::stateWidth-1:0] nextState;
	logic [dmaPkg::channelIdxWidth-1:0] activeChannel;
	logic [dmaPkg::xferWidth-1:0] activeType;
	logic nextData;

	// single transfer sequence, a late HLDA only stretches hold request
	always_comb
	begin
		case (state)
			dmaPkg::stIdle:    nextState = requestValid ? dmaPkg::stHoldReq : dmaPkg::stIdle;
			dmaPkg::stHoldReq: nextState = hlda ? dmaPkg::stS1 : dmaPkg::stHoldReq;
			dmaPkg::stS1:      nextState = dmaPkg::stS2;
			dmaPkg::stS2:      nextState = dmaPkg::stS4;
			default:           nextState = dmaPkg::stIdle;
		endcase
	end

	assign activeType = transferType[activeChannel];
	// S2 and S4 carry DACK and the read strobe
	assign nextData = nextState == dmaPkg::stS2 || nextState == dmaPkg::stS4;

	// bus outputs come from the next state so they line up with the state register
	always_ff @(posedge busIf or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= dmaPkg::stIdle;
			hrq <= 1'b0;
			aen <= 1'b0;
			adstb <= 1'b0;
			dack <= '0;
			dmaIorN <= 1'b1;
			dmaIowN <= 1'b1;
			memrN <= 1'b1;
			memwN <= 1'b1;
			transferDone <= 1'b0;
		end
		else
		begin
			state <= nextState;
			hrq <= nextState != dmaPkg::stIdle;
			aen <= nextState == dmaPkg::stS1 || nextState == dmaPkg::stS2;
			adstb <= nextState == dmaPkg::stS1;
			dack <= '0;
			if (nextData)
				dack[activeChannel] <= 1'b1;
			// write: device drives data in S2, memory takes it in S4
			dmaIorN <= !(nextData && activeType == dmaPkg::xferWrite);
			memwN <= !(nextState == dmaPkg::stS4 && activeType == dmaPkg::xferWrite);
			// read: memory drives data in S2, device takes it in S4
			memrN <= !(nextData && activeType == dmaPkg::xferRead);
			dmaIowN <= !(nextState == dmaPkg::stS4 && activeType == dmaPkg::xferRead);
			// counters step at the end of S4
			transferDone <= nextState == dmaPkg::stS4;
		end
	end

	// channel held from the grant until the return to idle
	always_ff @(posedge busIf)
	begin
		if (state == dmaPkg::stIdle && requestValid)
			activeChannel <= grantChannel;
		// address captured on the way into S1, stable through S4
		if (state == dmaPkg::stHoldReq && hlda)
			addrOut <= curAddr[activeChannel];
	end

	assign doneChannel = activeChannel;

endmodule

`default_nettype wire

// ==== hdl/dmaPriorityArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module dmaPriorityArbiter (
	input  logic                               busIf,
	input  logic                               arstN,
	input  logic [dmaPkg::numChannels-1:0]     dreq,
	input  logic                               controllerDisable,
	input  logic                               rotatingPriority,
	input  logic                               transferDone,
	input  logic [dmaPkg::channelIdxWidth-1:0] doneChannel,
	output logic                               requestValid,
	output logic [dmaPkg::channelIdxWidth-1:0] grantChannel
);

	logic [dmaPkg::numChannels-1:0] qualReq;
	logic [dmaPkg::channelIdxWidth-1:0] topChannel;
	logic [dmaPkg::channelIdxWidth-1:0] startChannel;

	// a disabled controller sees no requests
	assign qualReq = controllerDisable ? '0 : dreq;

	// fixed priority starts the search at channel 0
	assign startChannel = rotatingPriority ? topChannel : '0;

	// after service the next channel becomes highest
	always_ff @(posedge busIf or negedge arstN)
	begin
		if (!arstN)
			topChannel <= '0;
		else if (transferDone)
			topChannel <= doneChannel + 1'b1;
	end

	// first requesting channel from the top of the order, wrapping around
	always_comb
	begin
		logic [dmaPkg::channelIdxWidth-1:0] candidate;
		requestValid = 1'b0;
		grantChannel = '0;
		for (int i = 0; i < dmaPkg::numChannels; i++)
		begin
			candidate = startChannel + dmaPkg::channelIdxWidth'(i);
			if (!requestValid && qualReq[candidate])
			begin
				requestValid = 1'b1;
				grantChannel = candidate;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/dmaChannelCounters.sv ====
`timescale 1ns/1ns
`default_nettype none

module dmaChannelCounters (
	input  logic                                              busIf,
	input  logic                                              arstN,
	input  logic                                              loadStrobe,
	input  logic [dmaPkg::channelIdxWidth-1:0]                loadChannel,
	input  logic                                              loadIsCount,
	input  logic                                              loadHigh,
	input  logic [dmaPkg::dataWidth-1:0]                      loadByte,
	input  logic [dmaPkg::channelIdxWidth-1:0]                readChannel,
	input  logic                                              readIsCount,
	input  logic                                              readHigh,
	input  logic [dmaPkg::numChannels-1:0][dmaPkg::addrWidth-1:0] baseAddr,
	input  logic [dmaPkg::numChannels-1:0][dmaPkg::addrWidth-1:0] baseCount,
	input  logic [dmaPkg::numChannels-1:0]                    autoInit,
	input  logic [dmaPkg::numChannels-1:0]                    addrDecrement,
	input  logic                                              transferDone,
	input  logic [dmaPkg::channelIdxWidth-1:0]                doneChannel,
	output logic [dmaPkg::dataWidth-1:0]                      curByte,
	output logic [dmaPkg::numChannels-1:0][dmaPkg::addrWidth-1:0] curAddr,
	output logic                                              tcPulse,
	output logic [dmaPkg::channelIdxWidth-1:0]                tcChannel
);

	logic [dmaPkg::numChannels-1:0][dmaPkg::addrWidth-1:0] curCount;
	logic [dmaPkg::addrWidth-1:0] readWord;
	logic atTerminal;

	// count wraps from zero to all ones on this transfer
	assign atTerminal = curCount[doneChannel] == '0;

	// current registers, a CPU load never meets a transfer
	always_ff @(posedge busIf)
	begin
		if (loadStrobe)
		begin
			if (loadIsCount)
				curCount[loadChannel][loadHigh*dmaPkg::dataWidth +: dmaPkg::dataWidth] <= loadByte;
			else
				curAddr[loadChannel][loadHigh*dmaPkg::dataWidth +: dmaPkg::dataWidth] <= loadByte;
		end
		else if (transferDone)
		begin
			if (atTerminal && autoInit[doneChannel])
			begin
				// autoinit, start over from the base values
				curAddr[doneChannel] <= baseAddr[doneChannel];
				curCount[doneChannel] <= baseCount[doneChannel];
			end
			else
			begin
				if (addrDecrement[doneChannel])
					curAddr[doneChannel] <= curAddr[doneChannel] - 1'b1;
				else
					curAddr[doneChannel] <= curAddr[doneChannel] + 1'b1;
				curCount[doneChannel] <= curCount[doneChannel] - 1'b1;
			end
		end
	end

	// one cycle TC pulse toward the status flags
	always_ff @(posedge busIf or negedge arstN)
	begin
		if (!arstN)
		begin
			tcPulse <= 1'b0;
			tcChannel <= '0;
		end
		else
		begin
			tcPulse <= transferDone && atTerminal;
			tcChannel <= doneChannel;
		end
	end

	// readback of one byte of a current register
	assign readWord = readIsCount ? curCount[readChannel] : curAddr[readChannel];
	assign curByte = readWord[readHigh*dmaPkg::dataWidth +: dmaPkg::dataWidth];

endmodule

`default_nettype wire

// ==== hdl/dmaRegisterFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module dmaRegisterFile (
	input  logic                                              busIf,
	input  logic                                              arstN,
	input  logic                                              csN,
	input  logic                                              iorN,
	input  logic                                              iowN,
	input  logic [dmaPkg::regIdxWidth-1:0]                    regIdx,
	input  logic [dmaPkg::dataWidth-1:0]                      dbIn,
	input  logic [dmaPkg::dataWidth-1:0]                      curByte,
	input  logic                                              tcPulse,
	input  logic [dmaPkg::channelIdxWidth-1:0]                tcChannel,
	output logic [dmaPkg::dataWidth-1:0]                      dbOut,
	output logic                                              dbOe,
	output logic                                              loadStrobe,
	output logic [dmaPkg::channelIdxWidth-1:0]                loadChannel,
	output logic                                              loadIsCount,
	output logic                                              loadHigh,
	output logic [dmaPkg::dataWidth-1:0]                      loadByte,
	output logic [dmaPkg::channelIdxWidth-1:0]                readChannel,
	output logic                                              readIsCount,
	output logic                                              readHigh,
	output logic [dmaPkg::numChannels-1:0][dmaPkg::addrWidth-1:0] baseAddr,
	output logic [dmaPkg::numChannels-1:0][dmaPkg::addrWidth-1:0] baseCount,
	output logic                                              controllerDisable,
	output logic                                              rotatingPriority,
	output logic [dmaPkg::numChannels-1:0][dmaPkg::xferWidth-1:0] transferType,
	output logic [dmaPkg::numChannels-1:0]                    autoInit,
	output logic [dmaPkg::numChannels-1:0]                    addrDecrement
);

	dmaPkg::dmaProgramWord progWord;
	dmaPkg::dmaProgramWord commandReg;
	dmaPkg::dmaProgramWord modeReg [dmaPkg::numChannels];
	logic readStrobe;
	logic writeStrobe;
	logic channelAccess;
	logic byteFf;
	logic [dmaPkg::numChannels-1:0] tcFlags;
	logic [dmaPkg::dataWidth-1:0] readData;

	// CPU strobes are one cycle wide
	assign readStrobe = !csN && !iorN;
	assign writeStrobe = !csN && !iowN;
	// indices 0 to 7 hit a channel register
	assign channelAccess = !regIdx[dmaPkg::regIdxWidth-1];
	assign progWord = dbIn;

	// byte select to the counters, even index is address, odd is count
	assign loadStrobe = writeStrobe && channelAccess;
	assign loadChannel = regIdx[dmaPkg::channelIdxWidth:1];
	assign loadIsCount = regIdx[0];
	assign loadHigh = byteFf;
	assign loadByte = dbIn;
	assign readChannel = regIdx[dmaPkg::channelIdxWidth:1];
	assign readIsCount = regIdx[0];
	assign readHigh = byteFf;

	// byte flip-flop, low byte first
	always_ff @(posedge busIf or negedge arstN)
	begin
		if (!arstN)
			byteFf <= 1'b0;
		else if (writeStrobe && regIdx == dmaPkg::regClearFf)
			byteFf <= 1'b0;
		else if ((readStrobe || writeStrobe) && channelAccess)
			byteFf <= !byteFf;
	end

	// command and mode registers
	always_ff @(posedge busIf or negedge arstN)
	begin
		if (!arstN)
		begin
			commandReg <= '0;
			for (int ch = 0; ch < dmaPkg::numChannels; ch++)
				modeReg[ch] <= '0;
		end
		else if (writeStrobe)
		begin
			if (regIdx == dmaPkg::regCmdStatus)
				commandReg <= progWord;
			// the mode byte names its own channel
			if (regIdx == dmaPkg::regMode)
				modeReg[progWord.mode.channelSel] <= progWord;
		end
	end

	// base registers, written together with the current ones
	always_ff @(posedge busIf)
	begin
		if (loadStrobe)
		begin
			if (loadIsCount)
				baseCount[loadChannel][loadHigh*dmaPkg::dataWidth +: dmaPkg::dataWidth] <= dbIn;
			else
				baseAddr[loadChannel][loadHigh*dmaPkg::dataWidth +: dmaPkg::dataWidth] <= dbIn;
		end
	end

	// terminal count flags, cleared by a status read
	always_ff @(posedge busIf or negedge arstN)
	begin
		if (!arstN)
			tcFlags <= '0;
		else
		begin
			if (readStrobe && regIdx == dmaPkg::regCmdStatus)
				tcFlags <= '0;
			// later assignment wins, so a new TC survives the clearing read
			if (tcPulse)
				tcFlags[tcChannel] <= 1'b1;
		end
	end

	// read mux, sampled at the end of the strobe cycle
	always_comb
	begin
		readData = '0;
		if (channelAccess)
			readData = curByte;
		else if (regIdx == dmaPkg::regCmdStatus)
			readData[dmaPkg::numChannels-1:0] = tcFlags;
	end

	always_ff @(posedge busIf)
	begin
		if (readStrobe)
			dbOut <= readData;
	end

	// data valid for the single cycle after the strobe
	always_ff @(posedge busIf or negedge arstN)
	begin
		if (!arstN)
			dbOe <= 1'b0;
		else
			dbOe <= readStrobe;
	end

	// decoded command and per-channel mode fields
	assign controllerDisable = commandReg.cmd.controllerDisable;
	assign rotatingPriority = commandReg.cmd.rotatingPriority;

	always_comb
	begin
		for (int ch = 0; ch < dmaPkg::numChannels; ch++)
		begin
			transferType[ch] = modeReg[ch].mode.transferType;
			autoInit[ch] = modeReg[ch].mode.autoInit;
			addrDecrement[ch] = modeReg[ch].mode.addrDecrement;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/dmaPkg.sv ====
`default_nettype none

package dmaPkg;

	// channel and bus geometry
	localparam int numChannels = 4;
	localparam int channelIdxWidth = 2;
	localparam int addrWidth = 16;
	localparam int dataWidth = 8;
	localparam int regIdxWidth = 4;
	localparam int xferWidth = 2;
	localparam int stateWidth = 5;

	// register indices, 0 to 7 are the channel address and count pairs
	localparam logic [regIdxWidth-1:0] regCmdStatus = 4'd8;
	localparam logic [regIdxWidth-1:0] regMode = 4'd11;
	localparam logic [regIdxWidth-1:0] regClearFf = 4'd12;

	// transfer types as coded in the mode byte
	localparam logic [xferWidth-1:0] xferVerify = 2'b00;
	// I/O to memory
	localparam logic [xferWidth-1:0] xferWrite = 2'b01;
	// memory to I/O
	localparam logic [xferWidth-1:0] xferRead = 2'b10;

	// one-hot transfer FSM states
	localparam logic [stateWidth-1:0] stIdle = 5'b00001;
	localparam logic [stateWidth-1:0] stHoldReq = 5'b00010;
	localparam logic [stateWidth-1:0] stS1 = 5'b00100;
	localparam logic [stateWidth-1:0] stS2 = 5'b01000;
	localparam logic [stateWidth-1:0] stS4 = 5'b10000;

	// one programming byte, read as a command or as a mode word
	typedef union packed {
		struct packed {
			logic [2:0] reservedHigh;
			logic       rotatingPriority;
			logic       reservedMid;
			logic       controllerDisable;
			logic [1:0] reservedLow;
		} cmd;
		struct packed {
			// stored only, single transfer is always used
			logic [1:0] modeSelect;
			logic       addrDecrement;
			logic       autoInit;
			logic [1:0] transferType;
			logic [1:0] channelSel;
		} mode;
	} dmaProgramWord;

endpackage

`default_nettype wire
